/* proto_pkg.sv */
package proto_pkg;

	localparam int CMD_BYTES = 8;

	// --------------------------------------------------
	// opcodes, byte 0 of every command
	// --------------------------------------------------
	localparam logic [7:0] OP_READOUT   = 8'd0;
	localparam logic [7:0] OP_PLL_RESET = 8'd1;
	localparam logic [7:0] OP_VERSION   = 8'd2;
	localparam logic [7:0] OP_SPI       = 8'd3;
	localparam logic [7:0] OP_ARM       = 8'd5;

	localparam logic [31:0] FW_VERSION   = 32'd9;
	localparam logic [31:0] PLL_ACK      = 32'd33;
	localparam logic [31:0] ANSWER_BYTES = 32'd4;

	// byte 7 is the msb, byte 0 the lsb
	typedef union packed {
		struct packed {
			logic [7:0]  count;  // 2 or 3 bytes
			logic [15:0] unused;
			logic [7:0]  d4;
			logic [7:0]  d3;
			logic [7:0]  d2;
			logic [7:0]  chip;
			logic [7:0]  opcode;
		} spi;
		struct packed {
			logic [15:0] unused_hi;
			logic [15:0] count;  // sample pairs
			logic [15:0] unused_lo;
			logic [7:0]  trig;
			logic [7:0]  opcode;
		} arm;
		struct packed {
			logic [31:0] len;    // bytes to stream
			logic [23:0] unused;
			logic [7:0]  opcode;
		} readout;
	} cmd_word_u;

endpackage

/* acq_pkg.sv */
package acq_pkg;

	localparam int SAMPLE_W = 12;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef sample_t [1:0] pair_t;  // [0] earlier sample, [1] later one

	// threshold trigger, below lower then above upper
	localparam sample_t LOWER_THRESH = -12'sd10;
	localparam sample_t UPPER_THRESH = 12'sd10;

	localparam int FIFO_DEPTH = 64;
	localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

	localparam logic [7:0] TRIG_NOW    = 8'd0;
	localparam logic [7:0] TRIG_THRESH = 8'd1;

endpackage

/* ctrl_ifs.sv */
`timescale 1ns/1ps

// dispatch to spi sequencer
interface spi_req_if;
	logic            start;        // one-cycle pulse
	logic [2:0]      chip;
	logic [2:0][7:0] data;         // command bytes 2, 3, 4
	logic            three_bytes;
	logic            done;         // one-cycle pulse
	logic [7:0]      rx_byte;      // valid with done

	modport master (output start, chip, data, three_bytes, input done, rx_byte);
	modport slave  (input start, chip, data, three_bytes, output done, rx_byte);
endinterface

// dispatch to output stream packer
interface tx_req_if;
	logic        start;
	logic        const_mode;  // send word, else fifo pairs
	logic [31:0] word;
	logic [31:0] byte_len;
	logic        done;

	modport master (output start, const_mode, word, byte_len, input done);
	modport slave  (input start, const_mode, word, byte_len, output done);
endinterface

/* cmd_receiver.sv */
`timescale 1ns/1ps

module cmd_receiver (
	input  logic                  clk,
	input  logic                  rstn,
	input  logic                  i_valid,
	input  logic [7:0]            i_data,
	input  logic                  i_done,
	output logic                  o_ready,
	output proto_pkg::cmd_word_u  o_cmd,
	output logic                  o_cmd_valid
);
	import proto_pkg::*;

	logic [CMD_BYTES-1:0][7:0]    bytes;
	logic [$clog2(CMD_BYTES)-1:0] cnt;
	logic                         collecting;

	assign o_ready = collecting;
	assign o_cmd   = cmd_word_u'(bytes);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			collecting  <= 1'b1;
			cnt         <= '0;
			o_cmd_valid <= 1'b0;
		end else begin
			o_cmd_valid <= 1'b0;
			if (collecting && i_valid) begin
				cnt <= cnt + 1'b1;  // wraps back to byte 0
				if (cnt == CMD_BYTES - 1) begin
					collecting  <= 1'b0;
					o_cmd_valid <= 1'b1;
				end
			end else if (!collecting && i_done) begin
				collecting <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (collecting && i_valid)
			bytes[cnt] <= i_data;
	end

endmodule

/* cmd_dispatch.sv */
`timescale 1ns/1ps

module cmd_dispatch (
	input  logic                 clk,
	input  logic                 rstn,
	input  proto_pkg::cmd_word_u i_cmd,
	input  logic                 i_cmd_valid,
	output logic                 o_done,
	output logic                 o_pll_reset,
	output logic                 o_arm,
	output logic [7:0]           o_trig_type,
	output logic [15:0]          o_pair_count,
	spi_req_if.master            spi,
	tx_req_if.master             tx
);
	import proto_pkg::*;

	enum logic [1:0] {S_IDLE, S_SPI, S_TX} state;

	logic [7:0] op;

	assign op           = i_cmd.readout.opcode;
	assign spi.chip     = i_cmd.spi.chip[2:0];
	assign spi.data     = {i_cmd.spi.d4, i_cmd.spi.d3, i_cmd.spi.d2};
	assign spi.three_bytes = (i_cmd.spi.count != 8'd2);
	assign o_trig_type  = i_cmd.arm.trig;
	assign o_pair_count = i_cmd.arm.count;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state       <= S_IDLE;
			o_done      <= 1'b0;
			o_pll_reset <= 1'b0;
			o_arm       <= 1'b0;
			spi.start   <= 1'b0;
			tx.start    <= 1'b0;
		end else begin
			o_done      <= 1'b0;
			o_pll_reset <= 1'b0;
			o_arm       <= 1'b0;
			spi.start   <= 1'b0;
			tx.start    <= 1'b0;
			case (state)
				S_IDLE: if (i_cmd_valid) begin
					case (op)
						OP_PLL_RESET: begin
							o_pll_reset <= 1'b1;
							tx.start    <= 1'b1;
							state       <= S_TX;
						end
						OP_VERSION: begin
							tx.start <= 1'b1;
							state    <= S_TX;
						end
						OP_SPI: begin
							spi.start <= 1'b1;
							state     <= S_SPI;
						end
						OP_ARM: begin
							o_arm  <= 1'b1;
							o_done <= 1'b1;  // no answer
						end
						OP_READOUT: begin
							if (i_cmd.readout.len != 32'd0) begin
								tx.start <= 1'b1;
								state    <= S_TX;
							end else begin
								o_done <= 1'b1;
							end
						end
						default: o_done <= 1'b1;  // unknown, dropped
					endcase
				end
				S_SPI: if (spi.done) begin
					tx.start <= 1'b1;
					state    <= S_TX;
				end
				S_TX: if (tx.done) begin
					o_done <= 1'b1;
					state  <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// answer word, byte count and mode for the packer
	always_ff @(posedge clk) begin
		if (state == S_IDLE && i_cmd_valid) begin
			tx.const_mode <= (op != OP_READOUT);
			tx.byte_len   <= (op == OP_READOUT) ? i_cmd.readout.len : ANSWER_BYTES;
			tx.word       <= (op == OP_PLL_RESET) ? PLL_ACK : FW_VERSION;
		end else if (state == S_SPI && spi.done) begin
			tx.word <= {24'd0, spi.rx_byte};
		end
	end

endmodule

/* spi_sequencer.sv */
`timescale 1ns/1ps

module spi_sequencer (
	input  logic       clk,
	input  logic       rstn,
	input  logic       i_spi_tx_ready,
	input  logic [7:0] i_spi_rx,
	input  logic       i_spi_rx_dv,
	output logic [7:0] o_spi_tx,
	output logic       o_spi_tx_dv,
	output logic [7:0] o_spi_cs,
	spi_req_if.slave   spi
);

	enum logic [1:0] {S_IDLE, S_SEND, S_GAP, S_RX} state;

	logic [1:0] idx;
	logic       last_byte;

	assign o_spi_tx    = spi.data[idx];
	assign o_spi_tx_dv = (state == S_SEND) && i_spi_tx_ready;
	assign last_byte   = spi.three_bytes ? (idx == 2'd2) : (idx == 2'd1);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state    <= S_IDLE;
			idx      <= 2'd0;
			o_spi_cs <= 8'hff;
			spi.done <= 1'b0;
		end else begin
			spi.done <= 1'b0;
			case (state)
				S_IDLE: if (spi.start) begin
					o_spi_cs <= ~(8'd1 << spi.chip);  // select one chip
					idx      <= 2'd0;
					state    <= S_SEND;
				end
				S_SEND: if (i_spi_tx_ready) begin
					state <= last_byte ? S_RX : S_GAP;
				end
				S_GAP: begin  // master drops ready after dv
					idx   <= idx + 2'd1;
					state <= S_SEND;
				end
				S_RX: if (i_spi_rx_dv) begin
					o_spi_cs <= 8'hff;
					spi.done <= 1'b1;
					state    <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_RX && i_spi_rx_dv)
			spi.rx_byte <= i_spi_rx;
	end

endmodule

/* acq_config.sv */
`timescale 1ns/1ps

module acq_config (
	input  logic        clk,
	input  logic        rstn,
	input  logic        i_arm,
	input  logic [7:0]  i_trig_type,
	input  logic [15:0] i_pair_count,
	input  logic        i_acq_done,
	output logic        o_live,
	output logic [7:0]  o_trig_type,
	output logic [15:0] o_pair_count
);
	import acq_pkg::*;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			o_live <= 1'b0;
		else if (i_acq_done)
			o_live <= 1'b0;
		else if (i_arm)
			o_live <= 1'b1;  // rearm while live has no effect
	end

	always_ff @(posedge clk) begin
		if (i_arm && !o_live) begin
			o_trig_type  <= (i_trig_type == TRIG_THRESH) ? TRIG_THRESH : TRIG_NOW;
			o_pair_count <= (i_pair_count > FIFO_DEPTH) ? 16'(FIFO_DEPTH) : i_pair_count;
		end
	end

endmodule

/* acq_engine.sv */
`timescale 1ns/1ps

module acq_engine (
	input  logic             clk,
	input  logic             rstn,
	input  acq_pkg::sample_t i_sample,
	input  logic             i_sample_valid,
	input  logic             i_live,
	input  logic [7:0]       i_trig_type,
	input  logic [15:0]      i_pair_count,
	input  logic             i_fifo_full,
	output logic             o_wr,
	output acq_pkg::pair_t   o_pair,
	output logic             o_acq_done
);
	import acq_pkg::*;

	enum logic [1:0] {S_IDLE, S_WAIT_LOW, S_WAIT_HIGH, S_CAPTURE} state;

	logic [15:0] pairs;
	logic        half;   // first sample of a pair held
	sample_t     first;

	// ends in the same cycle the config drops live
	assign o_acq_done = (state == S_CAPTURE) && ((pairs >= i_pair_count) || i_fifo_full);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= S_IDLE;
			pairs <= 16'd0;
			half  <= 1'b0;
			o_wr  <= 1'b0;
		end else begin
			o_wr <= 1'b0;
			case (state)
				S_IDLE: begin
					pairs <= 16'd0;
					half  <= 1'b0;
					if (i_live) begin
						if (i_trig_type == TRIG_THRESH)
							state <= S_WAIT_LOW;
						else
							state <= S_CAPTURE;
					end
				end
				S_WAIT_LOW: if (i_sample_valid && i_sample < LOWER_THRESH) begin
					state <= S_WAIT_HIGH;
				end
				S_WAIT_HIGH: if (i_sample_valid && i_sample > UPPER_THRESH) begin
					state <= S_CAPTURE;
				end
				S_CAPTURE: begin
					if (o_acq_done) begin
						state <= S_IDLE;
					end else if (i_sample_valid) begin
						half <= !half;
						if (half) begin
							o_wr  <= 1'b1;
							pairs <= pairs + 16'd1;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_CAPTURE && i_sample_valid && !o_acq_done) begin
			if (!half)
				first <= i_sample;
			else
				o_pair <= {i_sample, first};  // later sample on top
		end
	end

endmodule

/* sample_fifo.sv */
`timescale 1ns/1ps

module sample_fifo (
	input  logic           clk,
	input  logic           rstn,
	input  logic           i_wr,
	input  acq_pkg::pair_t i_wdata,
	input  logic           i_rd,
	output acq_pkg::pair_t o_rdata,
	output logic           o_empty,
	output logic           o_full
);
	import acq_pkg::*;

	pair_t              mem [FIFO_DEPTH];
	logic [FIFO_AW:0]   wr_ptr;  // extra msb tells full from empty
	logic [FIFO_AW:0]   rd_ptr;

	assign o_rdata = mem[rd_ptr[FIFO_AW-1:0]];
	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
	                 (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (i_wr && !o_full)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_rd && !o_empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (i_wr && !o_full)
			mem[wr_ptr[FIFO_AW-1:0]] <= i_wdata;
	end

endmodule

/* tx_packer.sv */
`timescale 1ns/1ps

module tx_packer (
	input  logic           clk,
	input  logic           rstn,
	input  logic           i_out_ready,
	input  acq_pkg::pair_t i_fifo_data,
	input  logic           i_fifo_empty,
	output logic           o_out_valid,
	output logic [31:0]    o_out_data,
	output logic [3:0]     o_out_keep,
	output logic           o_out_last,
	output logic           o_fifo_rd,
	tx_req_if.slave        tx
);

	enum logic [1:0] {S_IDLE, S_FETCH, S_SEND} state;

	logic [31:0] remaining;  // counts the current word too
	logic        const_mode;

	assign o_fifo_rd  = (state == S_FETCH) && !i_fifo_empty;
	assign o_out_last = (remaining <= 32'd4);

	always_comb begin
		case (remaining)
			32'd1:   o_out_keep = 4'b0001;
			32'd2:   o_out_keep = 4'b0011;
			32'd3:   o_out_keep = 4'b0111;
			default: o_out_keep = 4'b1111;
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state       <= S_IDLE;
			remaining   <= 32'd0;
			const_mode  <= 1'b0;
			o_out_valid <= 1'b0;
			tx.done     <= 1'b0;
		end else begin
			tx.done <= 1'b0;
			case (state)
				S_IDLE: if (tx.start) begin
					remaining  <= tx.byte_len;
					const_mode <= tx.const_mode;
					if (tx.const_mode) begin
						o_out_valid <= 1'b1;
						state       <= S_SEND;
					end else begin
						state <= S_FETCH;
					end
				end
				S_FETCH: if (!i_fifo_empty) begin
					o_out_valid <= 1'b1;
					state       <= S_SEND;
				end
				S_SEND: if (i_out_ready) begin
					if (o_out_last) begin
						o_out_valid <= 1'b0;
						tx.done     <= 1'b1;
						state       <= S_IDLE;
					end else begin
						remaining <= remaining - 32'd4;
						if (!const_mode) begin
							o_out_valid <= 1'b0;
							state       <= S_FETCH;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && tx.start)
			o_out_data <= tx.word;
		else if (o_fifo_rd)
			o_out_data <= {4'd0, i_fifo_data[1], 4'd0, i_fifo_data[0]};
	end

endmodule

/* scope_ctrl_top.sv */
`timescale 1ns/1ps

module scope_ctrl_top (
	input  logic             clk,
	input  logic             rstn,
	input  logic             i_in_valid,
	input  logic [7:0]       i_in_data,
	input  logic             i_out_ready,
	input  logic             i_spi_tx_ready,
	input  logic [7:0]       i_spi_rx,
	input  logic             i_spi_rx_dv,
	input  acq_pkg::sample_t i_sample,
	input  logic             i_sample_valid,
	output logic             o_in_ready,
	output logic             o_out_valid,
	output logic [31:0]      o_out_data,
	output logic [3:0]       o_out_keep,
	output logic             o_out_last,
	output logic             o_pll_reset,
	output logic [7:0]       o_spi_tx,
	output logic             o_spi_tx_dv,
	output logic [7:0]       o_spi_cs
);
	import proto_pkg::*;
	import acq_pkg::*;

	cmd_word_u   cmd;
	logic        cmd_valid, cmd_done;
	logic        arm, live, acq_done;
	logic [7:0]  arm_type, live_type;
	logic [15:0] arm_count, live_count;
	logic        fifo_wr, fifo_rd, fifo_empty, fifo_full;
	pair_t       wr_pair, rd_pair;

	spi_req_if u_spi_req ();
	tx_req_if  u_tx_req ();

	// --------------------------------------------------
	// command path
	// --------------------------------------------------
	cmd_receiver u_cmd_receiver (
		.clk(clk), .rstn(rstn), .i_valid(i_in_valid), .i_data(i_in_data),
		.i_done(cmd_done), .o_ready(o_in_ready), .o_cmd(cmd), .o_cmd_valid(cmd_valid)
	);

	cmd_dispatch u_cmd_dispatch (
		.clk(clk), .rstn(rstn), .i_cmd(cmd), .i_cmd_valid(cmd_valid),
		.o_done(cmd_done), .o_pll_reset(o_pll_reset), .o_arm(arm),
		.o_trig_type(arm_type), .o_pair_count(arm_count),
		.spi(u_spi_req.master), .tx(u_tx_req.master)
	);

	spi_sequencer u_spi_sequencer (
		.clk(clk), .rstn(rstn), .i_spi_tx_ready(i_spi_tx_ready), .i_spi_rx(i_spi_rx),
		.i_spi_rx_dv(i_spi_rx_dv), .o_spi_tx(o_spi_tx), .o_spi_tx_dv(o_spi_tx_dv),
		.o_spi_cs(o_spi_cs), .spi(u_spi_req.slave)
	);

	// --------------------------------------------------
	// acquisition and readout
	// --------------------------------------------------
	acq_config u_acq_config (
		.clk(clk), .rstn(rstn), .i_arm(arm), .i_trig_type(arm_type),
		.i_pair_count(arm_count), .i_acq_done(acq_done), .o_live(live),
		.o_trig_type(live_type), .o_pair_count(live_count)
	);

	acq_engine u_acq_engine (
		.clk(clk), .rstn(rstn), .i_sample(i_sample), .i_sample_valid(i_sample_valid),
		.i_live(live), .i_trig_type(live_type), .i_pair_count(live_count),
		.i_fifo_full(fifo_full), .o_wr(fifo_wr), .o_pair(wr_pair), .o_acq_done(acq_done)
	);

	sample_fifo u_sample_fifo (
		.clk(clk), .rstn(rstn), .i_wr(fifo_wr), .i_wdata(wr_pair), .i_rd(fifo_rd),
		.o_rdata(rd_pair), .o_empty(fifo_empty), .o_full(fifo_full)
	);

	tx_packer u_tx_packer (
		.clk(clk), .rstn(rstn), .i_out_ready(i_out_ready), .i_fifo_data(rd_pair),
		.i_fifo_empty(fifo_empty), .o_out_valid(o_out_valid), .o_out_data(o_out_data),
		.o_out_keep(o_out_keep), .o_out_last(o_out_last), .o_fifo_rd(fifo_rd),
		.tx(u_tx_req.slave)
	);

endmodule

/* tb_scope_ctrl.sv */
`timescale 1ns/1ps

module tb_scope_ctrl;

	localparam int K_CONST   = 0;
	localparam int K_SPI     = 1;
	localparam int K_ARM     = 2;
	localparam int K_READOUT = 3;
	localparam int K_NONE    = 4;
	localparam logic [31:0] ANY_FIRST = 32'hffff_ffff;

	logic               clk;
	logic               rstn;
	logic               i_in_valid;
	logic [7:0]         i_in_data;
	logic               i_out_ready;
	logic               i_spi_tx_ready;
	logic [7:0]         i_spi_rx;
	logic               i_spi_rx_dv;
	logic signed [11:0] i_sample;
	logic               i_sample_valid;
	logic               o_in_ready;
	logic               o_out_valid;
	logic [31:0]        o_out_data;
	logic [3:0]         o_out_keep;
	logic               o_out_last;
	logic               o_pll_reset;
	logic [7:0]         o_spi_tx;
	logic               o_spi_tx_dv;
	logic [7:0]         o_spi_cs;

	// one table row per command
	string       row_name [$];
	logic [63:0] row_cmd [$];
	int          row_kind [$];
	logic [31:0] row_value [$];

	logic [31:0] rx_data [$];  // accepted stream words
	logic [3:0]  rx_keep [$];
	logic        rx_last [$];
	logic [7:0]  spi_got [$];
	logic [2:0]  spi_chip;
	int          pll_pulses;
	logic        restart_ramp;
	int          errors;
	int          tests;
	int          failed;

	scope_ctrl_top u_scope_ctrl_top (
		.clk(clk), .rstn(rstn), .i_in_valid(i_in_valid), .i_in_data(i_in_data),
		.i_out_ready(i_out_ready), .i_spi_tx_ready(i_spi_tx_ready), .i_spi_rx(i_spi_rx),
		.i_spi_rx_dv(i_spi_rx_dv), .i_sample(i_sample), .i_sample_valid(i_sample_valid),
		.o_in_ready(o_in_ready), .o_out_valid(o_out_valid), .o_out_data(o_out_data),
		.o_out_keep(o_out_keep), .o_out_last(o_out_last), .o_pll_reset(o_pll_reset),
		.o_spi_tx(o_spi_tx), .o_spi_tx_dv(o_spi_tx_dv), .o_spi_cs(o_spi_cs)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	task automatic next_cycle;
		@(posedge clk);
		#1;
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic add_row(input string name, input logic [63:0] cmd, input int kind,
	                       input logic [31:0] value);
		row_name.push_back(name);
		row_cmd.push_back(cmd);
		row_kind.push_back(kind);
		row_value.push_back(value);
	endtask

	// byte 0 goes first and waits for ready
	task automatic send_cmd(input logic [63:0] cmd);
		int   i;
		logic rdy;
		i = 0;
		while (i < 8) begin
			i_in_valid = 1'b1;
			i_in_data  = cmd[i*8 +: 8];
			rdy        = o_in_ready;
			next_cycle;
			if (rdy)
				i++;
		end
		i_in_valid = 1'b0;
	endtask

	task automatic check_readout(input logic [31:0] len, input logic [31:0] first_exp);
		int          i;
		int          nwords;
		logic [31:0] rem;
		logic [3:0]  keep_exp;
		logic [11:0] base;
		logic [11:0] first_smp;
		logic [11:0] second_smp;
		nwords = (len + 3) / 4;
		base   = first_exp[11:0];
		check_eq("word count", rx_data.size(), nwords);
		if (first_exp == ANY_FIRST && rx_data.size() > 0)
			base = rx_data[0][11:0];  // start of the ramp window
		for (i = 0; i < nwords && i < rx_data.size(); i++) begin
			rem        = len - 4 * i;
			keep_exp   = (rem >= 4) ? 4'b1111 : 4'((1 << rem) - 1);
			first_smp  = base + 12'(2 * i);  // ramp wraps at 12 bits
			second_smp = first_smp + 12'd1;
			check_eq("o_out_keep", rx_keep[i], keep_exp);
			check_eq("o_out_last", rx_last[i], rem <= 4);
			check_eq("o_out_data pad", {rx_data[i][31:28], rx_data[i][15:12]}, 0);
			if (i > 0 || first_exp != ANY_FIRST)
				check_eq("first sample", rx_data[i][11:0], first_smp);
			check_eq("second sample", rx_data[i][27:16], second_smp);
		end
	endtask

	task automatic run_row(input int r);
		int          errs_before;
		int          k;
		int          spi_nbytes;
		logic [63:0] cmd;
		cmd         = row_cmd[r];
		errs_before = errors;
		rx_data.delete();
		rx_keep.delete();
		rx_last.delete();
		spi_got.delete();
		pll_pulses = 0;
		spi_chip   = cmd[10:8];
		spi_nbytes = (cmd[63:56] == 8'd2) ? 2 : 3;
		if (row_kind[r] == K_ARM)
			restart_ramp = 1'b1;
		send_cmd(cmd);
		while (!o_in_ready)
			next_cycle;
		repeat (20) next_cycle;  // anything late would show here
		check_eq("o_pll_reset pulses", pll_pulses, cmd[7:0] == 8'd1);
		if (row_kind[r] != K_SPI)
			check_eq("spi byte count", spi_got.size(), 0);
		case (row_kind[r])
			K_CONST, K_SPI: begin
				check_eq("word count", rx_data.size(), 1);
				if (rx_data.size() > 0) begin
					check_eq("o_out_data", rx_data[0], row_value[r]);
					check_eq("o_out_keep", rx_keep[0], 4'b1111);
					check_eq("o_out_last", rx_last[0], 1'b1);
				end
				if (row_kind[r] == K_SPI) begin
					check_eq("spi byte count", spi_got.size(), spi_nbytes);
					for (k = 0; k < spi_got.size(); k++)
						check_eq("o_spi_tx", spi_got[k], cmd[(k+2)*8 +: 8]);
				end
			end
			K_READOUT: check_readout(cmd[63:32], row_value[r]);
			default:   check_eq("word count", rx_data.size(), 0);
		endcase
		tests++;
		if (errors != errs_before)
			failed++;
		$display("test %0d %s: %s", r, row_name[r], (errors == errs_before) ? "ok" : "failed");
	endtask

	// --------------------------------------------------
	// stream sink with random ready
	// --------------------------------------------------
	initial begin : stream_sink
		logic        held;
		logic [31:0] held_data;
		logic        rdy;
		i_out_ready = 1'b0;
		held        = 1'b0;
		held_data   = '0;
		forever begin
			next_cycle;
			if (held) begin
				check_eq("o_out_valid stalled", o_out_valid, 1'b1);
				check_eq("o_out_data stalled", o_out_data, held_data);
			end
			if (o_pll_reset)
				pll_pulses++;
			rdy         = ($urandom % 4) != 0;
			i_out_ready = rdy;
			if (o_out_valid && rdy) begin  // taken at the next edge
				rx_data.push_back(o_out_data);
				rx_keep.push_back(o_out_keep);
				rx_last.push_back(o_out_last);
			end
			held      = o_out_valid && !rdy;
			held_data = o_out_data;
		end
	end

	// --------------------------------------------------
	// spi master model
	// --------------------------------------------------
	initial begin : spi_model
		logic [7:0] x;
		logic [7:0] cs_exp;
		logic       more;
		int         waited;
		i_spi_tx_ready = 1'b0;
		i_spi_rx       = 8'd0;
		i_spi_rx_dv    = 1'b0;
		forever begin
			next_cycle;
			if (o_spi_cs != 8'hff) begin
				x                = 8'd0;
				more             = 1'b1;
				cs_exp           = 8'hff;
				cs_exp[spi_chip] = 1'b0;  // only the addressed chip
				while (more) begin
					repeat ($urandom % 4) next_cycle;
					i_spi_tx_ready = 1'b1;
					#1;
					waited = 0;
					while (!o_spi_tx_dv && waited < 4) begin
						next_cycle;
						#1;
						waited++;
					end
					if (o_spi_tx_dv) begin
						check_eq("o_spi_cs", o_spi_cs, cs_exp);
						spi_got.push_back(o_spi_tx);
						x = x ^ o_spi_tx;
					end else begin
						more = 1'b0;  // no further byte offered
					end
					next_cycle;
					i_spi_tx_ready = 1'b0;
				end
				repeat ($urandom % 4) next_cycle;
				i_spi_rx    = x;  // xor of all bytes sent
				i_spi_rx_dv = 1'b1;
				next_cycle;
				i_spi_rx_dv = 1'b0;
			end
		end
	end

	// ramp from -40 that restarts on each arm
	initial begin : sample_model
		logic signed [11:0] ramp;
		ramp           = -12'sd40;
		i_sample       = ramp;
		i_sample_valid = 1'b0;
		forever begin
			next_cycle;
			if (i_sample_valid)
				ramp = ramp + 12'sd1;
			if (restart_ramp) begin
				ramp         = -12'sd40;
				restart_ramp = 1'b0;
			end
			i_sample       = ramp;
			i_sample_valid = ($urandom % 2) != 0;
		end
	end

	initial begin : watchdog
		#1;
		repeat (row_cmd.size() * 2000) @(posedge clk);
		$display("watchdog: the tests did not finish within %0d cycles", row_cmd.size() * 2000);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		int r;
		void'($urandom(61));
		rstn         = 1'b0;
		i_in_valid   = 1'b0;
		i_in_data    = 8'd0;
		restart_ramp = 1'b0;
		spi_chip     = 3'd0;
		pll_pulses   = 0;
		errors       = 0;
		tests        = 0;
		failed       = 0;

		add_row("version",          64'h0000000000000002, K_CONST,   32'd9);
		add_row("pll reset",        64'h0000000000000001, K_CONST,   32'd33);
		add_row("spi 3 bytes",      64'h0300000F3CA50503, K_SPI,     32'h96);
		add_row("spi 2 bytes",      64'h02000077C35A0203, K_SPI,     32'h99);
		add_row("arm now 4",        64'h0000000400000005, K_ARM,     32'd0);
		add_row("readout 16",       64'h0000001000000000, K_READOUT, ANY_FIRST);
		add_row("arm thresh 3",     64'h0000000300000105, K_ARM,     32'd0);
		add_row("readout 12",       64'h0000000C00000000, K_READOUT, 32'd12);
		add_row("arm now 2",        64'h0000000200000005, K_ARM,     32'd0);
		add_row("readout 6",        64'h0000000600000000, K_READOUT, ANY_FIRST);
		add_row("unknown opcode",   64'h1122334455667707, K_NONE,    32'd0);
		add_row("version again",    64'h0000000000000002, K_CONST,   32'd9);

		repeat (10) @(posedge clk);
		#1;
		rstn = 1'b1;
		check_eq("o_in_ready", o_in_ready, 1'b1);
		check_eq("o_out_valid", o_out_valid, 1'b0);
		check_eq("o_spi_tx_dv", o_spi_tx_dv, 1'b0);
		check_eq("o_spi_cs", o_spi_cs, 8'hff);
		check_eq("o_pll_reset", o_pll_reset, 1'b0);
		next_cycle;

		for (r = 0; r < row_cmd.size(); r++)
			run_row(r);

		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* project.f */
proto_pkg.sv
acq_pkg.sv
ctrl_ifs.sv
cmd_receiver.sv
cmd_dispatch.sv
spi_sequencer.sv
acq_config.sv
acq_engine.sv
sample_fifo.sv
tx_packer.sv
scope_ctrl_top.sv
tb_scope_ctrl.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_scope_ctrl -f project.f -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi
exit 0
